// File: logic/gmii_tx_pkg.sv
package gmii_tx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int LEN_W = 12;          // frame length field in pointer word
    localparam int PTR_W = 16;          // pointer fifo word, length in low bits

    ////////////////////////////////////////////////////////////////////////////
    // line constants
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hd5;
    localparam int         PREAMBLE_LEN  = 8;   // sfd included
    localparam int         FCS_LEN       = 4;

    localparam logic [31:0] CRC_INIT        = 32'hffff_ffff;
    localparam logic [31:0] CRC_RESIDUE_XOR = 32'hffff_ffff;   // final inversion
    localparam logic [31:0] CRC_POLY        = 32'hedb8_8320;   // reflected 802.3

    // one stream byte between the stages
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       first;  // first payload byte (fetch) / first preamble byte (framer)
        logic       last;   // last payload byte
    } tx_byte_t;

    ////////////////////////////////////////////////////////////////////////////
    // crc step
    ////////////////////////////////////////////////////////////////////////////

    // one byte into the running crc, lsb first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// File: logic/gmii_tx_fetch.sv
`timescale 1ns/1ps

module gmii_tx_fetch import gmii_tx_pkg::*; (
    input  logic             tx_master_clk,
    input  logic             rstn_mac,
    // normal queue
    input  logic             ptr_fifo_empty,
    input  logic [PTR_W-1:0] ptr_fifo_din,
    output logic             ptr_fifo_rd,
    input  logic [7:0]       data_fifo_din,
    output logic             data_fifo_rd,
    // tte queue
    input  logic             tptr_fifo_empty,
    input  logic [PTR_W-1:0] tptr_fifo_din,
    output logic             tptr_fifo_rd,
    input  logic [7:0]       tdata_fifo_din,
    output logic             tdata_fifo_rd,
    // line side
    input  logic             line_busy,
    output tx_byte_t         fetch_byte
);

    localparam logic [1:0] ST_IDLE = 2'd0;  // wait for a queue and a free line
    localparam logic [1:0] ST_PTR  = 2'd1;  // pointer strobe
    localparam logic [1:0] ST_LEN  = 2'd2;  // pointer word arrives and length is latched
    localparam logic [1:0] ST_DATA = 2'd3;  // one data strobe per cycle

    logic [1:0]       state;
    logic             sel_tte;      // queue of the frame in flight
    logic             wait_line;    // frame launched and line_busy not yet seen
    logic [LEN_W-1:0] len_q;
    logic [LEN_W-1:0] rd_cnt;
    logic             data_rd;
    logic [PTR_W-1:0] ptr_word;
    logic             rd_valid_q;
    logic             rd_first_q;
    logic             rd_last_q;

    assign ptr_word = sel_tte ? tptr_fifo_din : ptr_fifo_din;
    assign data_rd  = (state == ST_DATA);

    assign ptr_fifo_rd   = (state == ST_PTR) && !sel_tte;
    assign tptr_fifo_rd  = (state == ST_PTR) && sel_tte;
    assign data_fifo_rd  = data_rd && !sel_tte;
    assign tdata_fifo_rd = data_rd && sel_tte;

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state     <= ST_IDLE;
            sel_tte   <= 1'b0;
            wait_line <= 1'b0;
            len_q     <= '0;
            rd_cnt    <= '0;
        end else begin
            if (line_busy) begin
                wait_line <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    // tte wins whenever it has a frame waiting
                    if (!line_busy && !wait_line && (!tptr_fifo_empty || !ptr_fifo_empty)) begin
                        sel_tte   <= !tptr_fifo_empty;
                        wait_line <= 1'b1;
                        state     <= ST_PTR;
                    end
                end
                ST_PTR: state <= ST_LEN;
                ST_LEN: begin
                    len_q  <= ptr_word[LEN_W-1:0];
                    rd_cnt <= LEN_W'(1);
                    state  <= ST_DATA;
                end
                default: begin
                    if (rd_cnt == len_q) begin
                        state <= ST_IDLE;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data fifo answers one cycle after the strobe
    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            rd_valid_q <= 1'b0;
            rd_first_q <= 1'b0;
            rd_last_q  <= 1'b0;
        end else begin
            rd_valid_q <= data_rd;
            rd_first_q <= data_rd && (rd_cnt == LEN_W'(1));
            rd_last_q  <= data_rd && (rd_cnt == len_q);
        end
    end

    always_comb begin
        fetch_byte.valid = rd_valid_q;
        fetch_byte.data  = sel_tte ? tdata_fifo_din : data_fifo_din;
        fetch_byte.first = rd_first_q;
        fetch_byte.last  = rd_last_q;
    end

    a_len_nonzero: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (state == ST_LEN) |=> (len_q != '0));

    // a pointer strobe only goes to a queue that holds a frame
    a_ptr_rd_not_empty: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(ptr_fifo_rd && ptr_fifo_empty) && !(tptr_fifo_rd && tptr_fifo_empty));

endmodule

// File: logic/gmii_tx_framer.sv
`timescale 1ns/1ps

module gmii_tx_framer import gmii_tx_pkg::*; (
    input  logic     tx_master_clk,
    input  logic     rstn_mac,
    input  tx_byte_t fetch_byte,
    output tx_byte_t frame_byte
);

    localparam int LINE_W = 8 * PREAMBLE_LEN;

    // resting contents, first byte out sits in the low byte
    localparam logic [LINE_W-1:0] PREAMBLE_LOAD = {SFD_BYTE, {(PREAMBLE_LEN-1){PREAMBLE_BYTE}}};

    ////////////////////////////////////////////////////////////////////////////
    // delay line
    ////////////////////////////////////////////////////////////////////////////

    logic [LINE_W-1:0]       line_data;
    logic [PREAMBLE_LEN-1:0] line_last;     // last flag per slot
    logic                    draining;      // input done, line still emptying
    logic                    shift;
    logic                    tail_out;      // last payload byte leaves now

    assign shift    = fetch_byte.valid || draining;
    assign tail_out = shift && line_last[0];

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            line_data <= PREAMBLE_LOAD;
            line_last <= '0;
            draining  <= 1'b0;
        end else if (tail_out) begin
            // frame gone, preload for the next one
            line_data <= PREAMBLE_LOAD;
            line_last <= '0;
            draining  <= 1'b0;
        end else if (shift) begin
            line_data <= {fetch_byte.data, line_data[LINE_W-1:8]};
            line_last <= {fetch_byte.valid && fetch_byte.last, line_last[PREAMBLE_LEN-1:1]};
            if (fetch_byte.valid && fetch_byte.last) begin
                draining <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            frame_byte <= '0;
        end else begin
            frame_byte.valid <= shift;
            frame_byte.data  <= line_data[7:0];
            frame_byte.first <= fetch_byte.valid && fetch_byte.first;  // first 0x55 leaves
            frame_byte.last  <= tail_out;
        end
    end

    // fetch must not start a frame before the previous one has left the line
    a_no_overlap: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        (fetch_byte.valid && fetch_byte.first) |-> !draining);

endmodule

// File: logic/gmii_tx_fcs.sv
`timescale 1ns/1ps

module gmii_tx_fcs import gmii_tx_pkg::*; #(
    parameter int IFG_CYCLES = 12
) (
    input  logic     tx_master_clk,
    input  logic     rstn_mac,
    input  tx_byte_t frame_byte,
    output logic [7:0] gtx_d,
    output logic     gtx_dv,
    output logic     line_busy
);

    localparam int GAP_W = $clog2(IFG_CYCLES + 1);
    localparam int PRE_W = $clog2(PREAMBLE_LEN + 1);

    localparam logic [1:0] PH_IDLE  = 2'd0;
    localparam logic [1:0] PH_FRAME = 2'd1;    // preamble and payload pass through
    localparam logic [1:0] PH_FCS   = 2'd2;    // crc bytes, lsb first
    localparam logic [1:0] PH_GAP   = 2'd3;    // inter-frame gap

    logic [1:0]       phase;
    logic [PRE_W-1:0] pre_cnt;
    logic [1:0]       fcs_cnt;
    logic [GAP_W-1:0] gap_cnt;
    logic [31:0]      crc;
    logic [31:0]      crc_next;
    logic [31:0]      fcs_sr;
    logic             payload;

    assign payload   = frame_byte.valid && !frame_byte.first && (pre_cnt == PRE_W'(PREAMBLE_LEN));
    assign crc_next  = crc32_byte(crc, frame_byte.data);
    assign line_busy = frame_byte.valid || (phase != PH_IDLE);

    // crc over payload only
    always_ff @(posedge tx_master_clk) begin
        if (frame_byte.valid && frame_byte.first) begin
            crc <= CRC_INIT;
        end else if (payload) begin
            crc <= crc_next;
        end
        if (payload && frame_byte.last) begin
            fcs_sr <= crc_next ^ CRC_RESIDUE_XOR;
        end else if (phase == PH_FCS) begin
            fcs_sr <= fcs_sr >> 8;
        end
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            phase   <= PH_IDLE;
            pre_cnt <= '0;
            fcs_cnt <= '0;
            gap_cnt <= '0;
            gtx_dv  <= 1'b0;
            gtx_d   <= '0;
        end else begin
            if (frame_byte.valid) begin
                if (frame_byte.first) begin
                    pre_cnt <= PRE_W'(1);
                end else if (pre_cnt != PRE_W'(PREAMBLE_LEN)) begin
                    pre_cnt <= pre_cnt + 1'b1;
                end
            end
            case (phase)
                PH_IDLE: if (frame_byte.valid && frame_byte.first) phase <= PH_FRAME;
                PH_FRAME: begin
                    if (frame_byte.valid && frame_byte.last) begin
                        fcs_cnt <= '0;
                        phase   <= PH_FCS;
                    end
                end
                PH_FCS: begin
                    fcs_cnt <= fcs_cnt + 1'b1;
                    if (fcs_cnt == 2'(FCS_LEN - 1)) begin
                        gap_cnt <= GAP_W'(IFG_CYCLES);
                        phase   <= PH_GAP;
                    end
                end
                default: begin
                    gap_cnt <= gap_cnt - 1'b1;
                    if (gap_cnt == GAP_W'(1)) phase <= PH_IDLE;
                end
            endcase
            // registered gmii output
            if (frame_byte.valid) begin
                gtx_dv <= 1'b1;
                gtx_d  <= frame_byte.data;
            end else if (phase == PH_FCS) begin
                gtx_dv <= 1'b1;
                gtx_d  <= fcs_sr[7:0];
            end else begin
                gtx_dv <= 1'b0;
                gtx_d  <= '0;
            end
        end
    end

    a_quiet_after_tail: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        frame_byte.valid |-> (phase == PH_IDLE || phase == PH_FRAME));

endmodule

// File: logic/gmii_tx_top.sv
`timescale 1ns/1ps

module gmii_tx_top import gmii_tx_pkg::*; #(
    parameter int IFG_CYCLES = 12
) (
    input  logic             tx_master_clk,
    input  logic             rstn_mac,
    // normal queue
    output logic             ptr_fifo_rd,
    input  logic [PTR_W-1:0] ptr_fifo_din,
    input  logic             ptr_fifo_empty,
    output logic             data_fifo_rd,
    input  logic [7:0]       data_fifo_din,
    // tte queue
    output logic             tptr_fifo_rd,
    input  logic [PTR_W-1:0] tptr_fifo_din,
    input  logic             tptr_fifo_empty,
    output logic             tdata_fifo_rd,
    input  logic [7:0]       tdata_fifo_din,
    // gmii
    output logic [7:0]       gtx_d,
    output logic             gtx_dv
);

    tx_byte_t fetch_byte;   // payload from the queues
    tx_byte_t frame_byte;   // preamble + payload
    logic     line_busy;

    gmii_tx_fetch u_fetch (
        .tx_master_clk   (tx_master_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .data_fifo_rd    (data_fifo_rd),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .line_busy       (line_busy),
        .fetch_byte      (fetch_byte)
    );

    gmii_tx_framer u_framer (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .fetch_byte    (fetch_byte),
        .frame_byte    (frame_byte)
    );

    gmii_tx_fcs #(
        .IFG_CYCLES (IFG_CYCLES)
    ) u_fcs (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .frame_byte    (frame_byte),
        .gtx_d         (gtx_d),
        .gtx_dv        (gtx_dv),
        .line_busy     (line_busy)
    );

endmodule

// File: dv/gmii_tx_tb.sv
`timescale 1ns/1ps

module gmii_tx_tb;

    logic        tx_master_clk;
    logic        rstn_mac;
    logic        ptr_fifo_rd, tptr_fifo_rd, data_fifo_rd, tdata_fifo_rd;
    logic [15:0] ptr_fifo_din, tptr_fifo_din;
    logic        ptr_fifo_empty, tptr_fifo_empty;
    logic [7:0]  data_fifo_din, tdata_fifo_din;
    logic [7:0]  gtx_d;
    logic        gtx_dv;

    int seed = 32866;
    int checks = 0;
    int errors = 0;

    // fifo contents and expected wire bytes in priority order
    logic [15:0] nptr_q[$], tptr_q[$];
    logic [7:0]  ndata_q[$], tdata_q[$];
    int          stage_len_t[$], stage_len_n[$], exp_len[$];
    logic [7:0]  stage_byte_t[$], stage_byte_n[$], exp_bytes[$];

    // monitor state
    logic [7:0] cur_frame[$];
    bit         in_frame = 0;
    int         cur_len = 0;
    int         dv_cnt = 0;
    int         gap = 0;
    int         frames_seen = 0;
    bit         pop_nptr = 0, pop_tptr = 0, pop_ndata = 0, pop_tdata = 0;

    gmii_tx_top #(.IFG_CYCLES(12)) uut (
        .tx_master_clk   (tx_master_clk),
        .rstn_mac        (rstn_mac),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .data_fifo_rd    (data_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .gtx_d           (gtx_d),
        .gtx_dv          (gtx_dv)
    );

    initial begin
        tx_master_clk = 1'b0;
        forever #50 tx_master_clk = ~tx_master_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // 802.3 crc-32 in its shift-left form over the bits as they go on the wire
    function automatic logic [31:0] fcs_of(input logic [7:0] pay[$]);
        logic [31:0] r;
        logic [31:0] refl;
        logic        fb;
        r = 32'hffff_ffff;
        foreach (pay[i]) begin
            for (int k = 0; k < 8; k++) begin
                fb = r[31] ^ pay[i][k];     // lsb of each byte leaves first
                r  = {r[30:0], 1'b0};
                if (fb) begin
                    r = r ^ 32'h04c1_1db7;
                end
            end
        end
        // complemented, x^31 term goes out first
        for (int k = 0; k < 32; k++) begin
            refl[k] = ~r[31-k];
        end
        return refl;
    endfunction

    task automatic add_frame(input bit tte);
        int          len;
        logic [7:0]  pay[$];
        logic [7:0]  wire_b[$];
        logic [31:0] c;
        len = 1 + int'({$random(seed)} % 64);
        for (int i = 0; i < len; i++) begin
            pay.push_back(8'($random(seed)));
        end
        c = fcs_of(pay);
        for (int i = 0; i < 7; i++) begin
            wire_b.push_back(8'h55);
        end
        wire_b.push_back(8'hd5);
        foreach (pay[i]) wire_b.push_back(pay[i]);
        for (int i = 0; i < 4; i++) begin
            wire_b.push_back(c[8*i +: 8]);   // lsb first
        end
        if (tte) begin
            tptr_q.push_back(16'(len));
            foreach (pay[i]) tdata_q.push_back(pay[i]);
            stage_len_t.push_back(len);
            foreach (wire_b[i]) stage_byte_t.push_back(wire_b[i]);
        end else begin
            nptr_q.push_back(16'(len));
            foreach (pay[i]) ndata_q.push_back(pay[i]);
            stage_len_n.push_back(len);
            foreach (wire_b[i]) stage_byte_n.push_back(wire_b[i]);
        end
    endtask

    // tte frames go out ahead of everything normal
    task automatic flush_stages();
        while (stage_len_t.size() > 0) exp_len.push_back(stage_len_t.pop_front());
        while (stage_byte_t.size() > 0) exp_bytes.push_back(stage_byte_t.pop_front());
        while (stage_len_n.size() > 0) exp_len.push_back(stage_len_n.pop_front());
        while (stage_byte_n.size() > 0) exp_bytes.push_back(stage_byte_n.pop_front());
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // fifo models
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge tx_master_clk) begin
        pop_nptr  = ptr_fifo_rd;
        pop_tptr  = tptr_fifo_rd;
        pop_ndata = data_fifo_rd;
        pop_tdata = tdata_fifo_rd;
    end

    // word appears one cycle after the strobe
    always @(posedge tx_master_clk) begin
        #1;
        if (pop_nptr) begin
            if (nptr_q.size() == 0) begin
                $display("normal pointer FIFO read while empty");
                errors++;
            end else ptr_fifo_din = nptr_q.pop_front();
        end
        if (pop_tptr) begin
            if (tptr_q.size() == 0) begin
                $display("tte pointer FIFO read while empty");
                errors++;
            end else tptr_fifo_din = tptr_q.pop_front();
        end
        if (pop_ndata) begin
            if (ndata_q.size() == 0) begin
                $display("normal data FIFO read while empty");
                errors++;
            end else data_fifo_din = ndata_q.pop_front();
        end
        if (pop_tdata) begin
            if (tdata_q.size() == 0) begin
                $display("tte data FIFO read while empty");
                errors++;
            end else tdata_fifo_din = tdata_q.pop_front();
        end
        ptr_fifo_empty  = (nptr_q.size() == 0);
        tptr_fifo_empty = (tptr_q.size() == 0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // line monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge tx_master_clk) begin
        if (rstn_mac && gtx_dv) begin
            if (!in_frame) begin
                in_frame = 1;
                dv_cnt   = 0;
                cur_frame.delete();
                if (frames_seen > 0) begin
                    checks++;
                    assert (gap >= 12) else begin
                        $display("CHECK FAILED gtx_dv gap expected >= %h actual %h", 12, gap);
                        errors++;
                    end
                end
                if (exp_len.size() == 0) begin
                    $display("gtx_dv rose with no frame left in the model");
                    errors++;
                    cur_len = -1;
                end else begin
                    cur_len = exp_len.pop_front();
                    for (int i = 0; i < 12 + cur_len; i++) begin
                        cur_frame.push_back(exp_bytes.pop_front());
                    end
                end
            end
            if (dv_cnt < cur_frame.size()) begin
                checks++;
                assert (gtx_d == cur_frame[dv_cnt]) else begin
                    $display("CHECK FAILED gtx_d frame %0d byte %0d expected %h actual %h",
                             frames_seen, dv_cnt, cur_frame[dv_cnt], gtx_d);
                    errors++;
                end
            end
            dv_cnt++;
        end else if (rstn_mac) begin
            if (in_frame) begin
                in_frame = 0;
                gap      = 0;
                if (cur_len >= 0) begin
                    checks++;
                    assert (dv_cnt == 12 + cur_len) else begin
                        $display("CHECK FAILED gtx_dv length expected %h actual %h",
                                 12 + cur_len, dv_cnt);
                        errors++;
                    end
                end
                frames_seen++;
            end
            gap++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_outputs_low();
        checks++;
        assert (!gtx_dv && !ptr_fifo_rd && !tptr_fifo_rd && !data_fifo_rd && !tdata_fifo_rd)
        else begin
            $display("CHECK FAILED gtx_dv and strobes expected %h actual %h", 5'h0,
                     {gtx_dv, ptr_fifo_rd, tptr_fifo_rd, data_fifo_rd, tdata_fifo_rd});
            errors++;
        end
    endtask

    task automatic wait_frames(input int target);
        int cyc;
        cyc = 0;
        while (frames_seen < target && cyc < 200 * target + 500) begin
            @(posedge tx_master_clk);
            cyc++;
        end
        if (frames_seen < target) begin
            $display("timeout after %0d cycles, %0d of %0d frames seen", cyc, frames_seen, target);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %s", name, (errors == err_before) ? "pass" : "fail");
    endtask

    initial begin
        int e0;
        rstn_mac        = 1'b0;
        ptr_fifo_din    = '0;
        tptr_fifo_din   = '0;
        data_fifo_din   = '0;
        tdata_fifo_din  = '0;
        ptr_fifo_empty  = 1'b1;
        tptr_fifo_empty = 1'b1;

        // first batch with both queues loaded before reset
        for (int i = 0; i < 8; i++) add_frame(i[0]);
        flush_stages();

        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            @(negedge tx_master_clk);
            check_outputs_low();
        end
        @(posedge tx_master_clk);
        #1 rstn_mac = 1'b1;
        @(negedge tx_master_clk);
        check_outputs_low();
        report_test("reset", e0);

        e0 = errors;
        wait_frames(8);
        report_test("preloaded priority batch", e0);

        // line idle again before the second batch
        repeat (30) @(posedge tx_master_clk);
        @(negedge tx_master_clk);
        for (int i = 0; i < 8; i++) add_frame(1'({$random(seed)} % 2));
        flush_stages();
        e0 = errors;
        wait_frames(16);
        report_test("random queue batch", e0);

        e0 = errors;
        checks++;
        assert (nptr_q.size() == 0 && tptr_q.size() == 0 && ndata_q.size() == 0 &&
                tdata_q.size() == 0 && exp_len.size() == 0 && exp_bytes.size() == 0)
        else begin
            $display("model queues still hold data after the last frame");
            errors++;
        end
        for (int i = 0; i < 200; i++) begin
            @(negedge tx_master_clk);
            checks++;
            assert (!gtx_dv) else begin
                $display("CHECK FAILED gtx_dv expected %h actual %h", 1'b0, gtx_dv);
                errors++;
            end
        end
        report_test("drain and quiet line", e0);

        $display("frames %0d, checks %0d, errors %0d", frames_seen, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: gmii_tx_top.f
logic/gmii_tx_pkg.sv
logic/gmii_tx_fetch.sv
logic/gmii_tx_framer.sv
logic/gmii_tx_fcs.sv
logic/gmii_tx_top.sv
dv/gmii_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the gmii tx testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f gmii_tx_top.f --top-module gmii_tx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vgmii_tx_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$out"; then
    exit 0
fi
exit 1
